//--- Makefile
TB_TOP = icache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module icache_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o icache_sim
	./obj_dir/icache_sim | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir

//--- design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int ICACHE_SET = icache_pkg::ICACHE_SET_DEF,
    parameter int ICACHE_WAY = icache_pkg::ICACHE_WAY_DEF,
    parameter int ICACHE_BANK = icache_pkg::ICACHE_BANK_DEF,
    localparam int IDX_W = $clog2(ICACHE_SET),
    localparam int OFF_W = $clog2(ICACHE_BANK * icache_pkg::WORD_BYTES),
    localparam int TAG_W = $bits(icache_pkg::addr_t) - IDX_W - OFF_W,
    localparam int WAY_W = (ICACHE_WAY > 1) ? $clog2(ICACHE_WAY) : 1
) (
    input logic clk,
    input logic rst_n,
    input logic fetch_req,
    input icache_pkg::addr_t fetch_addr,
    output logic fetch_ack,
    output icache_pkg::word_t [ICACHE_BANK-1:0] fetch_line,
    output logic fetch_hit,
    output logic fetch_next_hit,
    output logic mem_req,
    output icache_pkg::addr_t mem_addr,
    input logic mem_ack,
    input icache_pkg::word_t [ICACHE_BANK-1:0] mem_line,
    icache_ram_if.ctrl ram,
    output logic [TAG_W-1:0] cmp_tag,
    output logic last_set,
    input logic hit,
    input logic [WAY_W-1:0] hit_way,
    input logic next_hit,
    input icache_pkg::word_t [ICACHE_BANK-1:0] line
);
    import icache_pkg::*;

    ctrl_state_t state;
    addr_t addr_q;
    word_t [ICACHE_BANK-1:0] fill_line;
    logic [IDX_W-1:0] set_idx;
    logic [IDX_W-1:0] init_cnt;
    logic init_done;
    logic missed;
    logic [WAY_W-1:0] rr_ptr;
    logic [WAY_W-1:0] fill_way;
    logic [ICACHE_WAY-1:0] way_sel;
    logic ram_on;
    logic filling;

    assign set_idx = addr_q[OFF_W +: IDX_W];
    assign cmp_tag = addr_q[$bits(addr_t)-1 -: TAG_W];
    assign last_set = (set_idx == IDX_W'(ICACHE_SET - 1));
    assign mem_addr = {addr_q[$bits(addr_t)-1:OFF_W], {OFF_W{1'b0}}};

    assign filling = (state == FILL);
    assign ram_on = (state == LOOKUP) || filling;
    assign way_sel = ICACHE_WAY'(1) << rr_ptr;

    // ####################
    // ram requests
    // ####################

    assign ram.tagv_en = ram_on;
    assign ram.tagv_we = filling ? way_sel : '0;
    assign ram.tagv_index = set_idx;
    assign ram.tagv_windex = set_idx;
    assign ram.tagv_wdata = {1'b1, cmp_tag};
    assign ram.en = {ICACHE_BANK{ram_on}};

    always_comb begin
        for (int b = 0; b < ICACHE_BANK; b++) begin
            ram.we[b] = filling ? way_sel : '0;
            ram.index[b] = set_idx;
            ram.wdata[b] = fill_line[b];
        end
    end

    // ####################
    // fsm
    // ####################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            fetch_ack <= 1'b0;
            fetch_hit <= 1'b0;
            fetch_next_hit <= 1'b0;
            mem_req <= 1'b0;
            missed <= 1'b0;
            rr_ptr <= '0;
            init_cnt <= '0;
            init_done <= 1'b0;
        end else begin
            // tag rams clear themselves over ICACHE_SET cycles
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == IDX_W'(ICACHE_SET - 1)) begin
                    init_done <= 1'b1;
                end
            end
            case (state)
                IDLE: begin
                    if (fetch_req && init_done) begin
                        missed <= 1'b0;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: state <= COMPARE;
                COMPARE: begin
                    if (hit) begin
                        fetch_ack <= 1'b1;
                        fetch_hit <= !missed;
                        fetch_next_hit <= next_hit;
                        state <= RESPOND;
                    end else begin
                        missed <= 1'b1;
                        mem_req <= 1'b1;
                        state <= MEM_REQ;
                    end
                end
                MEM_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (!mem_ack) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    rr_ptr <= (rr_ptr == WAY_W'(ICACHE_WAY - 1)) ? '0 : rr_ptr + 1'b1;
                    state <= LOOKUP;
                end
                RESPOND: begin
                    if (!fetch_req) begin
                        fetch_ack <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && fetch_req) begin
            addr_q <= fetch_addr;
        end
        if (state == COMPARE && hit) begin
            fetch_line <= line;
        end
        if (state == MEM_REQ && mem_ack) begin
            fill_line <= mem_line;
        end
        if (filling) begin
            fill_way <= rr_ptr;
        end
    end

    a_no_ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == IDLE |-> !fetch_ack);

    a_mem_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack);

    // lookup after a refill must find the line in the way just written
    a_refill_hits: assert property (@(posedge clk) disable iff (!rst_n)
        state == COMPARE && missed |-> hit && hit_way == fill_way);

endmodule

//--- design/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array #(
    parameter int ICACHE_SET = icache_pkg::ICACHE_SET_DEF,
    parameter int ICACHE_WAY = icache_pkg::ICACHE_WAY_DEF,
    parameter int ICACHE_BANK = icache_pkg::ICACHE_BANK_DEF
) (
    input logic clk,
    input logic rst_n,
    icache_ram_if.array ram
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(ICACHE_SET);
    localparam int OFF_W = $clog2(ICACHE_BANK * WORD_BYTES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W;
    localparam int WORD_W = $bits(word_t);

    logic tagv_wr;
    logic [IDX_W-1:0] tagv_index_p1;
    logic [IDX_W-1:0] tagv_addr0;
    logic [IDX_W-1:0] tagv_addr1;

    assign tagv_wr = |ram.tagv_we;
    // wraps to set 0 past the last set
    assign tagv_index_p1 = ram.tagv_index + 1'b1;
    assign tagv_addr0 = tagv_wr ? ram.tagv_windex : ram.tagv_index;
    assign tagv_addr1 = tagv_wr ? ram.tagv_windex : tagv_index_p1;

    // ####################
    // tag/valid rams
    // ####################

    icache_spram #(
        .WIDTH(ICACHE_WAY * (TAG_W + 1)),
        .DEPTH(ICACHE_SET),
        .BYTES(ICACHE_WAY),
        .RESET(1'b1)
    ) tagv_ram0 (
        .clk(clk),
        .rst_n(rst_n),
        .en(ram.tagv_en),
        .we(ram.tagv_we),
        .addr(tagv_addr0),
        .wdata({ICACHE_WAY{ram.tagv_wdata}}),
        .rdata(ram.tagv0)
    );

    // same table again, read one set ahead
    icache_spram #(
        .WIDTH(ICACHE_WAY * (TAG_W + 1)),
        .DEPTH(ICACHE_SET),
        .BYTES(ICACHE_WAY),
        .RESET(1'b1)
    ) tagv_ram1 (
        .clk(clk),
        .rst_n(rst_n),
        .en(ram.tagv_en),
        .we(ram.tagv_we),
        .addr(tagv_addr1),
        .wdata({ICACHE_WAY{ram.tagv_wdata}}),
        .rdata(ram.tagv1)
    );

    // ####################
    // data banks
    // ####################

    for (genvar i = 0; i < ICACHE_BANK; i++) begin : bank
        icache_spram #(
            .WIDTH(ICACHE_WAY * WORD_W),
            .DEPTH(ICACHE_SET),
            .BYTES(ICACHE_WAY)
        ) spram (
            .clk(clk),
            .rst_n(rst_n),
            .en(ram.en[i]),
            .we(ram.we[i]),
            .addr(ram.index[i]),
            .wdata({ICACHE_WAY{ram.wdata[i]}}),
            .rdata(ram.data[i])
        );
    end

    // a tag write lands in the same way as the line it describes
    a_tag_with_line: assert property (@(posedge clk) disable iff (!rst_n)
        tagv_wr |-> (&ram.en) && (ram.we[0] == ram.tagv_we));

endmodule

//--- design/icache_hit_select.sv
`timescale 1ns/1ps

module icache_hit_select #(
    parameter int ICACHE_SET = icache_pkg::ICACHE_SET_DEF,
    parameter int ICACHE_WAY = icache_pkg::ICACHE_WAY_DEF,
    parameter int ICACHE_BANK = icache_pkg::ICACHE_BANK_DEF,
    localparam int IDX_W = $clog2(ICACHE_SET),
    localparam int OFF_W = $clog2(ICACHE_BANK * icache_pkg::WORD_BYTES),
    localparam int TAG_W = $bits(icache_pkg::addr_t) - IDX_W - OFF_W,
    localparam int WAY_W = (ICACHE_WAY > 1) ? $clog2(ICACHE_WAY) : 1
) (
    input logic clk,
    input logic rst_n,
    icache_ram_if.reader ram,
    input logic [TAG_W-1:0] cmp_tag,
    input logic last_set,
    output logic hit,
    output logic [WAY_W-1:0] hit_way,
    output logic next_hit,
    output icache_pkg::word_t [ICACHE_BANK-1:0] line
);
    logic [ICACHE_WAY-1:0] way_hit;
    logic [ICACHE_WAY-1:0] way_next;

    // valid bit sits above the tag
    always_comb begin
        for (int w = 0; w < ICACHE_WAY; w++) begin
            way_hit[w] = ram.tagv0[w][TAG_W] && (ram.tagv0[w][TAG_W-1:0] == cmp_tag);
            way_next[w] = ram.tagv1[w][TAG_W] && (ram.tagv1[w][TAG_W-1:0] == cmp_tag);
        end
    end

    assign hit = |way_hit;
    // next set belongs to another tag past the last set
    assign next_hit = !last_set && (|way_next);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ICACHE_WAY; w++) begin
            if (way_hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    always_comb begin
        for (int b = 0; b < ICACHE_BANK; b++) begin
            line[b] = ram.data[b][hit_way];
        end
    end

    a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit));

endmodule

//--- design/icache_pkg.sv
package icache_pkg;

    // ####################
    // basic widths
    // ####################

    parameter int ADDR_WIDTH = 16;
    parameter int WORD_WIDTH = 32;

    // bytes per instruction word
    parameter int WORD_BYTES = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // ####################
    // default geometry
    // ####################

    parameter int ICACHE_SET_DEF = 16;
    parameter int ICACHE_WAY_DEF = 2;
    parameter int ICACHE_BANK_DEF = 4;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        MEM_REQ,
        MEM_WAIT,
        FILL,
        RESPOND
    } ctrl_state_t;

endpackage

//--- design/icache_ram_if.sv
`timescale 1ns/1ps

interface icache_ram_if #(
    parameter int ICACHE_SET = icache_pkg::ICACHE_SET_DEF,
    parameter int ICACHE_WAY = icache_pkg::ICACHE_WAY_DEF,
    parameter int ICACHE_BANK = icache_pkg::ICACHE_BANK_DEF
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(ICACHE_SET);
    localparam int OFF_W = $clog2(ICACHE_BANK * WORD_BYTES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W;

    // tag/valid side, valid bit on top of each entry
    logic tagv_en;
    logic [ICACHE_WAY-1:0] tagv_we;
    logic [IDX_W-1:0] tagv_index;
    logic [IDX_W-1:0] tagv_windex;
    logic [TAG_W:0] tagv_wdata;
    logic [ICACHE_WAY-1:0][TAG_W:0] tagv0;
    logic [ICACHE_WAY-1:0][TAG_W:0] tagv1;

    // data banks
    logic [ICACHE_BANK-1:0] en;
    logic [ICACHE_BANK-1:0][ICACHE_WAY-1:0] we;
    logic [ICACHE_BANK-1:0][IDX_W-1:0] index;
    word_t [ICACHE_BANK-1:0] wdata;
    word_t [ICACHE_BANK-1:0][ICACHE_WAY-1:0] data;

    modport ctrl (
        output tagv_en, tagv_we, tagv_index, tagv_windex, tagv_wdata,
        output en, we, index, wdata
    );

    modport array (
        input tagv_en, tagv_we, tagv_index, tagv_windex, tagv_wdata,
        input en, we, index, wdata,
        output tagv0, tagv1, data
    );

    modport reader (
        input tagv0, tagv1, data
    );

endinterface

//--- design/icache_spram.sv
`timescale 1ns/1ps

module icache_spram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16,
    parameter int BYTES = 1,
    parameter bit RESET = 1'b0
) (
    input logic clk,
    input logic rst_n,
    input logic en,
    input logic [BYTES-1:0] we,
    input logic [$clog2(DEPTH)-1:0] addr,
    input logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata
);
    localparam int AW = $clog2(DEPTH);
    localparam int SLICE = WIDTH / BYTES;

    logic [WIDTH-1:0] mem [DEPTH];
    logic clr_busy;
    logic [AW-1:0] clr_addr;

    // clear walk, one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_busy <= RESET;
            clr_addr <= '0;
        end else if (clr_busy) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == AW'(DEPTH - 1)) begin
                clr_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_busy) begin
            mem[clr_addr] <= '0;
        end else if (en) begin
            for (int b = 0; b < BYTES; b++) begin
                if (we[b]) begin
                    mem[addr][b*SLICE +: SLICE] <= wdata[b*SLICE +: SLICE];
                end
            end
        end
    end

    // read-before-write, zero while the walk runs
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];
        end
    end

    a_we_needs_en: assert property (@(posedge clk) disable iff (!rst_n) |we |-> en);

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int ICACHE_SET = icache_pkg::ICACHE_SET_DEF,
    parameter int ICACHE_WAY = icache_pkg::ICACHE_WAY_DEF,
    parameter int ICACHE_BANK = icache_pkg::ICACHE_BANK_DEF
) (
    input logic clk,
    input logic rst_n,
    input logic fetch_req,
    input icache_pkg::addr_t fetch_addr,
    output logic fetch_ack,
    output icache_pkg::word_t [ICACHE_BANK-1:0] fetch_line,
    output logic fetch_hit,
    output logic fetch_next_hit,
    output logic mem_req,
    output icache_pkg::addr_t mem_addr,
    input logic mem_ack,
    input icache_pkg::word_t [ICACHE_BANK-1:0] mem_line
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(ICACHE_SET);
    localparam int OFF_W = $clog2(ICACHE_BANK * WORD_BYTES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W;
    localparam int WAY_W = (ICACHE_WAY > 1) ? $clog2(ICACHE_WAY) : 1;

    logic [TAG_W-1:0] cmp_tag;
    logic last_set;
    logic hit;
    logic [WAY_W-1:0] hit_way;
    logic next_hit;
    word_t [ICACHE_BANK-1:0] line;

    icache_ram_if #(
        .ICACHE_SET(ICACHE_SET),
        .ICACHE_WAY(ICACHE_WAY),
        .ICACHE_BANK(ICACHE_BANK)
    ) ram_if ();

    icache_ctrl #(
        .ICACHE_SET(ICACHE_SET),
        .ICACHE_WAY(ICACHE_WAY),
        .ICACHE_BANK(ICACHE_BANK)
    ) ctrl_inst (
        .clk(clk),
        .rst_n(rst_n),
        .fetch_req(fetch_req),
        .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack),
        .fetch_line(fetch_line),
        .fetch_hit(fetch_hit),
        .fetch_next_hit(fetch_next_hit),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line),
        .ram(ram_if.ctrl),
        .cmp_tag(cmp_tag),
        .last_set(last_set),
        .hit(hit),
        .hit_way(hit_way),
        .next_hit(next_hit),
        .line(line)
    );

    icache_data_array #(
        .ICACHE_SET(ICACHE_SET),
        .ICACHE_WAY(ICACHE_WAY),
        .ICACHE_BANK(ICACHE_BANK)
    ) data_array_inst (
        .clk(clk),
        .rst_n(rst_n),
        .ram(ram_if.array)
    );

    icache_hit_select #(
        .ICACHE_SET(ICACHE_SET),
        .ICACHE_WAY(ICACHE_WAY),
        .ICACHE_BANK(ICACHE_BANK)
    ) hit_select_inst (
        .clk(clk),
        .rst_n(rst_n),
        .ram(ram_if.reader),
        .cmp_tag(cmp_tag),
        .last_set(last_set),
        .hit(hit),
        .hit_way(hit_way),
        .next_hit(next_hit),
        .line(line)
    );

endmodule

//--- tests/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int SETS = ICACHE_SET_DEF;
    localparam int WAYS = ICACHE_WAY_DEF;
    localparam int BANKS = ICACHE_BANK_DEF;
    localparam int ADDR_W = $bits(addr_t);
    localparam int IDX_W = $clog2(SETS);
    localparam int OFF_W = $clog2(BANKS * WORD_BYTES);
    localparam int TAG_W = ADDR_W - IDX_W - OFF_W;
    localparam int CLK_PERIOD = 40;
    localparam int N_DIRECTED = 16;
    localparam int N_RANDOM = 200;
    localparam int WORST_MISS = 50;
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * (WORST_MISS + 20) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst_n;
    logic fetch_req;
    addr_t fetch_addr;
    logic fetch_ack;
    word_t [BANKS-1:0] fetch_line;
    logic fetch_hit;
    logic fetch_next_hit;
    logic mem_req;
    addr_t mem_addr;
    logic mem_ack;
    word_t [BANKS-1:0] mem_line;

    integer seed;
    logic [31:0] rnd;
    logic [31:0] mem_rnd;
    int mem_delay;
    addr_t rand_addr [N_RANDOM];
    int rand_hold [N_RANDOM];

    // reference model state
    logic [TAG_W-1:0] m_tag [SETS][WAYS];
    logic m_valid [SETS][WAYS];
    int m_rr;

    // expectations for the fetch in flight
    addr_t exp_addr;
    word_t [BANKS-1:0] exp_line;
    logic exp_hit;
    logic exp_next;
    int mem_base;
    int fetch_cnt;

    // compare process state
    int errors;
    int chk_cnt;
    int mem_rise_cnt;
    int req_cyc;
    logic ack_q;
    logic req_q;
    logic mem_req_q;
    logic mem_ack_q;
    word_t [BANKS-1:0] line_q;

    always #(CLK_PERIOD / 2) clk = ~clk;

    icache_top icache_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .fetch_req(fetch_req),
        .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack),
        .fetch_line(fetch_line),
        .fetch_hit(fetch_hit),
        .fetch_next_hit(fetch_next_hit),
        .mem_req(mem_req),
        .mem_addr(mem_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line)
    );

    // ####################
    // memory and model
    // ####################

    function automatic word_t mem_word(input addr_t a, input int i);
        word_t w;
        w = {a ^ 16'h3c5a, a + 16'(i * 273)};
        return w ^ (32'h9e3779b9 * 32'(i + 1));
    endfunction

    function automatic word_t [BANKS-1:0] memory_line(input addr_t a);
        word_t [BANKS-1:0] ln;
        for (int i = 0; i < BANKS; i++) begin
            ln[i] = mem_word(a, i);
        end
        return ln;
    endfunction

    function automatic addr_t line_addr(input addr_t a);
        return a & ~addr_t'(BANKS * WORD_BYTES - 1);
    endfunction

    function automatic int set_of(input addr_t a);
        return int'(a[OFF_W +: IDX_W]);
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic tag_present(input logic [TAG_W-1:0] tag, input int set);
        logic found;
        found = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // next line only counts inside the same tag, so never past the last set
    function automatic void ref_expect(input addr_t a, output word_t [BANKS-1:0] ln,
                                       output logic h, output logic nh);
        ln = memory_line(line_addr(a));
        h = tag_present(tag_of(a), set_of(a));
        nh = (set_of(a) != SETS - 1) && tag_present(tag_of(a), set_of(a) + 1);
    endfunction

    function automatic void model_fill(input addr_t a);
        m_tag[set_of(a)][m_rr] = tag_of(a);
        m_valid[set_of(a)][m_rr] = 1'b1;
        m_rr = (m_rr + 1) % WAYS;
    endfunction

    // memory responder, random delay before ack and before release
    initial begin
        mem_ack = 1'b0;
        mem_line = '0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_req && !mem_ack) begin
                mem_rnd = $random(seed);
                mem_delay = int'(mem_rnd % 32'd6);
                repeat (mem_delay) @(posedge clk);
                mem_line <= memory_line(mem_addr);
                mem_ack <= 1'b1;
                do @(posedge clk); while (mem_req);
                mem_rnd = $random(seed);
                mem_delay = int'(mem_rnd % 32'd4);
                repeat (mem_delay) @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    end

    // ####################
    // fetch driver
    // ####################

    task automatic run_fetch(input addr_t a, input int hold);
        word_t [BANKS-1:0] ln;
        logic h;
        logic nh;
        ref_expect(a, ln, h, nh);
        if (!h) begin
            model_fill(a);
        end
        exp_addr = a;
        exp_line = ln;
        exp_hit = h;
        exp_next = nh;
        mem_base = mem_rise_cnt;
        fetch_cnt++;
        @(posedge clk);
        fetch_req <= 1'b1;
        fetch_addr <= a;
        do @(posedge clk); while (!fetch_ack);
        repeat (hold) @(posedge clk);
        fetch_req <= 1'b0;
        do @(posedge clk); while (fetch_ack);
    endtask

    // ####################
    // compare
    // ####################

    always @(posedge clk) begin
        if (rst_n) begin
            if (fetch_ack && !ack_q) begin
                chk_cnt <= chk_cnt + 1;
                if (fetch_line !== exp_line) begin
                    $display("Fail %0t: addr %h line %h expected %h",
                             $time, exp_addr, fetch_line, exp_line);
                    errors++;
                end
                if (fetch_hit !== exp_hit) begin
                    $display("Fail %0t: addr %h hit %b expected %b",
                             $time, exp_addr, fetch_hit, exp_hit);
                    errors++;
                end
                if (fetch_next_hit !== exp_next) begin
                    $display("Fail %0t: addr %h next_hit %b expected %b",
                             $time, exp_addr, fetch_next_hit, exp_next);
                    errors++;
                end
                if (mem_rise_cnt - mem_base != (exp_hit ? 0 : 1)) begin
                    $display("Fail %0t: addr %h made %0d memory requests", $time,
                             exp_addr, mem_rise_cnt - mem_base);
                    errors++;
                end
                if (exp_hit && req_cyc != 3) begin
                    $display("Fail %0t: addr %h hit latency %0d expected 3",
                             $time, exp_addr, req_cyc);
                    errors++;
                end
                if (!req_q) begin
                    $display("fetch_ack rose at %0t with no fetch request", $time);
                    errors++;
                end
            end
            if (ack_q && fetch_ack && fetch_line !== line_q) begin
                $display("fetch_line changed at %0t while fetch_ack was held", $time);
                errors++;
            end
            if (ack_q && !fetch_ack && req_q) begin
                $display("fetch_ack dropped at %0t while fetch_req was still high", $time);
                errors++;
            end
            if (mem_req && !mem_req_q) begin
                mem_rise_cnt <= mem_rise_cnt + 1;
                if (mem_addr !== line_addr(exp_addr)) begin
                    $display("Fail %0t: mem_addr %h expected %h",
                             $time, mem_addr, line_addr(exp_addr));
                    errors++;
                end
                if (mem_ack_q) begin
                    $display("mem_req rose at %0t while mem_ack was still high", $time);
                    errors++;
                end
            end
            if (mem_req_q && !mem_req && !mem_ack_q) begin
                $display("mem_req dropped at %0t before mem_ack was seen", $time);
                errors++;
            end
        end
        if (fetch_req && !req_q) begin
            req_cyc <= 1;
        end else begin
            req_cyc <= req_cyc + 1;
        end
        ack_q <= fetch_ack;
        req_q <= fetch_req;
        mem_req_q <= mem_req;
        mem_ack_q <= mem_ack;
        line_q <= fetch_line;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    // ####################
    // test sequence
    // ####################

    initial begin
        rst_n = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        seed = 32'haab91a80;
        errors = 0;
        chk_cnt = 0;
        mem_rise_cnt = 0;
        req_cyc = 0;
        fetch_cnt = 0;
        ack_q = 1'b0;
        req_q = 1'b0;
        mem_req_q = 1'b0;
        mem_ack_q = 1'b0;
        m_rr = 0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end
        // four tags over all sets, so evictions happen often
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            rand_addr[i] = {6'b0, rnd[9:0]};
            rand_hold[i] = int'(rnd[13:12]);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // cold miss, then a hit on the same line
        run_fetch(16'h1234, 0);
        run_fetch(16'h1238, 0);

        // three tags into set 5, round-robin eviction
        run_fetch(16'h0150, 0);
        run_fetch(16'h0250, 0);
        run_fetch(16'h0350, 0);
        run_fetch(16'h0150, 0);
        run_fetch(16'h0250, 0);

        // next-line hint, and the last set
        run_fetch(16'h0760, 0);
        run_fetch(16'h0754, 0);
        run_fetch(16'h0758, 1);
        run_fetch(16'h0800, 0);
        run_fetch(16'h08f4, 0);
        run_fetch(16'h08f8, 0);

        // slow request release
        run_fetch(16'h0a10, 5);
        run_fetch(16'h0a10, 7);
        run_fetch(16'h0b20, 3);

        for (int i = 0; i < N_RANDOM; i++) begin
            run_fetch(rand_addr[i], rand_hold[i]);
        end

        repeat (5) @(posedge clk);
        if (chk_cnt != fetch_cnt) begin
            $display("only %0d of %0d fetches were checked", chk_cnt, fetch_cnt);
            errors++;
        end
        $display("fetches %0d, checked %0d, errors %0d", fetch_cnt, chk_cnt, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/icache_pkg.sv
design/icache_ram_if.sv
design/icache_spram.sv
design/icache_data_array.sv
design/icache_hit_select.sv
design/icache_ctrl.sv
design/icache_top.sv
tests/icache_tb.sv
